//--- hdl/flu_consts.svh
// Widths and operation group encodings for the RV32 fixed-latency unit
// FLU_RVC at 0 removes the 2-byte link step for compressed instructions
`ifndef FLU_CONSTS_SVH
`define FLU_CONSTS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
// Data word and address width
`define FLU_XLEN 32

// Scoreboard tag width
`define FLU_TRANS_ID_BITS 3

// CSR address width, taken from the low bits of operand_b
`define FLU_CSR_ADDR_BITS 12

// Operation field width
`define FLU_OP_BITS 6

// Compressed instruction support
`define FLU_RVC 1

// ------------------------------------------------------------
// Operation group bases
// ------------------------------------------------------------
// Members of a group count up from the base
// ALU base stays at zero so a silenced operand bus decodes as ADD
`define FLU_OP_GRP_ALU    6'h00
`define FLU_OP_GRP_BRANCH 6'h10
`define FLU_OP_GRP_JUMP   6'h18
`define FLU_OP_GRP_MULT   6'h20
`define FLU_OP_GRP_CSR    6'h30

`endif

//--- hdl/flu_pkg.sv
// Shared types of the fixed-latency unit
// Widths come from the constants header
`include "flu_consts.svh"

package flu_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [`FLU_XLEN-1:0]          xlen_t;
    typedef logic [`FLU_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`FLU_CSR_ADDR_BITS-1:0] csr_addr_t;

    // ------------------------------------------------------------
    // Operations
    // ------------------------------------------------------------
    typedef enum logic [`FLU_OP_BITS-1:0] {
        // Integer ALU
        ADD = `FLU_OP_GRP_ALU, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Branch compare, result goes to the branch unit
        EQ = `FLU_OP_GRP_BRANCH, NE, LTS, GES, LTU, GEU,
        // Unconditional jumps
        JAL = `FLU_OP_GRP_JUMP, JALR,
        // Multiplier
        MUL = `FLU_OP_GRP_MULT, MULH, MULHU, MULHSU,
        // CSR access through the single-entry buffer
        CSR_RW = `FLU_OP_GRP_CSR
    } fu_op_e;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    // Instruction as issued to the unit
    typedef struct packed {
        fu_op_e    operation;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // Prediction made by the frontend
    typedef struct packed {
        logic  predict_taken;
        xlen_t predict_address;
    } branch_predict_t;

    // Resolution sent back to the frontend
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t target_address;
        logic  is_taken;
        logic  is_mispredict;
    } bp_resolve_t;

endpackage

//--- hdl/flu_alu.sv
// Combinational integer ALU with branch comparator
// Shift amount is the low five bits of operand_b
`timescale 1ns/10ps
`include "flu_consts.svh"

module flu_alu (
    input  flu_pkg::fu_data_t fu_data_i,
    output flu_pkg::xlen_t    result_o,
    output logic              branch_res_o
);

    localparam int unsigned shamt_bits = $clog2(`FLU_XLEN);

    flu_pkg::xlen_t        operand_a;
    flu_pkg::xlen_t        operand_b;
    flu_pkg::xlen_t        operand_b_neg;
    flu_pkg::xlen_t        adder_result;
    logic                  adder_sub;
    logic                  adder_zero;
    logic                  cmp_signed;
    logic                  less;
    logic [shamt_bits-1:0] shamt;

    assign operand_a = fu_data_i.operand_a;
    assign operand_b = fu_data_i.operand_b;
    assign shamt     = operand_b[shamt_bits-1:0];

    // ------------------------------------------------------------
    // Adder, also used for the equality compares
    // ------------------------------------------------------------
    assign adder_sub     = fu_data_i.operation inside {flu_pkg::SUB, flu_pkg::EQ, flu_pkg::NE};
    assign operand_b_neg = adder_sub ? ~operand_b : operand_b;
    assign adder_result  = operand_a + operand_b_neg
                         + {{(`FLU_XLEN-1){1'b0}}, adder_sub};
    assign adder_zero    = (adder_result == '0);

    // Less-than on one extra bit, sign-extended only for signed compares
    assign cmp_signed = fu_data_i.operation inside {flu_pkg::SLT, flu_pkg::LTS, flu_pkg::GES};
    assign less = $signed({cmp_signed & operand_a[`FLU_XLEN-1], operand_a})
                < $signed({cmp_signed & operand_b[`FLU_XLEN-1], operand_b});

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operation)
            flu_pkg::ADD,
            flu_pkg::SUB:  result_o = adder_result;
            flu_pkg::AND:  result_o = operand_a & operand_b;
            flu_pkg::OR:   result_o = operand_a | operand_b;
            flu_pkg::XOR:  result_o = operand_a ^ operand_b;
            flu_pkg::SLL:  result_o = operand_a << shamt;
            flu_pkg::SRL:  result_o = operand_a >> shamt;
            flu_pkg::SRA:  result_o = $signed(operand_a) >>> shamt;
            flu_pkg::SLT,
            flu_pkg::SLTU: result_o = {{(`FLU_XLEN-1){1'b0}}, less};
            default:       result_o = '0;
        endcase
    end

    // Branch condition, jumps are taken in the branch unit regardless
    always_comb begin
        branch_res_o = 1'b0;
        case (fu_data_i.operation)
            flu_pkg::EQ:  branch_res_o = adder_zero;
            flu_pkg::NE:  branch_res_o = ~adder_zero;
            flu_pkg::LTS,
            flu_pkg::LTU: branch_res_o = less;
            flu_pkg::GES,
            flu_pkg::GEU: branch_res_o = ~less;
            default:      branch_res_o = 1'b0;
        endcase
    end

endmodule

//--- hdl/flu_branch_unit.sv
// Branch target, link address and misprediction check
// Not-taken branches resolve with the link address as target
`timescale 1ns/10ps
`include "flu_consts.svh"

module flu_branch_unit (
    input  flu_pkg::fu_data_t        fu_data_i,
    input  flu_pkg::xlen_t           pc_i,
    input  logic                     is_compressed_instr_i,
    input  logic                     branch_valid_i,
    input  logic                     fu_valid_i,
    input  logic                     branch_comp_res_i,
    input  flu_pkg::branch_predict_t branch_predict_i,
    output flu_pkg::xlen_t           link_o,
    output flu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                     resolve_branch_o
);

    localparam bit has_rvc = (`FLU_RVC != 0);

    flu_pkg::xlen_t link_step;
    flu_pkg::xlen_t next_pc;
    flu_pkg::xlen_t jump_base;
    flu_pkg::xlen_t jump_sum;
    flu_pkg::xlen_t target;
    logic           is_cond;
    logic           is_jalr;
    logic           is_jump;
    logic           taken;

    assign is_cond = fu_data_i.operation inside {flu_pkg::EQ, flu_pkg::NE, flu_pkg::LTS,
                                                 flu_pkg::GES, flu_pkg::LTU, flu_pkg::GEU};
    assign is_jalr = (fu_data_i.operation == flu_pkg::JALR);
    assign is_jump = fu_data_i.operation inside {flu_pkg::JAL, flu_pkg::JALR};

    // ------------------------------------------------------------
    // Link and target
    // ------------------------------------------------------------
    assign link_step = (has_rvc && is_compressed_instr_i) ? flu_pkg::xlen_t'(2)
                                                          : flu_pkg::xlen_t'(4);
    assign next_pc   = pc_i + link_step;
    assign link_o    = next_pc;

    // JALR is register relative with bit 0 forced low
    assign jump_base = is_jalr ? fu_data_i.operand_a : pc_i;
    assign jump_sum  = jump_base + fu_data_i.imm;
    assign target    = jump_sum & ~{{(`FLU_XLEN-1){1'b0}}, is_jalr};

    assign taken = is_jump | (is_cond & branch_comp_res_i);

    // ------------------------------------------------------------
    // Resolution
    // ------------------------------------------------------------
    always_comb begin
        resolved_branch_o    = '0;
        resolved_branch_o.pc = pc_i;
        resolve_branch_o     = 1'b0;
        if (branch_valid_i) begin
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.is_taken       = taken;
            resolved_branch_o.target_address = taken ? target : next_pc;
            // Wrong direction, or right direction with a wrong address
            resolved_branch_o.is_mispredict  =
                (taken != branch_predict_i.predict_taken) ||
                (taken && (target != branch_predict_i.predict_address));
            resolve_branch_o = 1'b1;
        end else if (fu_valid_i && branch_predict_i.predict_taken) begin
            // Predicted taken on something that is no branch at all
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.is_taken       = 1'b0;
            resolved_branch_o.target_address = next_pc;
            resolved_branch_o.is_mispredict  = 1'b1;
            resolve_branch_o = 1'b1;
        end
    end

endmodule

//--- hdl/flu_csr_buffer.sv
// Single-entry CSR address buffer
// Blocks further issue until the held CSR op commits or is flushed
`timescale 1ns/10ps
`include "flu_consts.svh"

module flu_csr_buffer (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  flu_pkg::fu_data_t  fu_data_i,
    input  logic               csr_valid_i,
    input  logic               csr_commit_i,
    output logic               csr_ready_o,
    output flu_pkg::xlen_t     csr_result_o,
    output flu_pkg::csr_addr_t csr_addr_o
);

    logic               csr_valid_q;
    flu_pkg::csr_addr_t csr_addr_q;

    // Operand goes straight through, the CSR file reads it again at retire
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_addr_o   = csr_addr_q;
    assign csr_ready_o  = ~csr_valid_q;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            csr_valid_q <= 1'b0;
        end else if (flush_i) begin
            csr_valid_q <= 1'b0;
        end else if (csr_valid_i) begin
            csr_valid_q <= 1'b1;
        end else if (csr_commit_i) begin
            csr_valid_q <= 1'b0;
        end
    end

    // Address capture
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            csr_addr_q <= fu_data_i.operand_b[`FLU_CSR_ADDR_BITS-1:0];
        end
    end

endmodule

//--- hdl/flu_mult.sv
// One-cycle multiplier, result and tag registered
// Always ready, a new operation may enter while the last one leaves
`timescale 1ns/10ps
`include "flu_consts.svh"

module flu_mult (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               mult_valid_i,
    input  flu_pkg::fu_data_t  fu_data_i,
    output flu_pkg::xlen_t     result_o,
    output logic               mult_valid_o,
    output flu_pkg::trans_id_t mult_trans_id_o
);

    logic                          sign_a;
    logic                          sign_b;
    logic signed [`FLU_XLEN:0]     operand_a_ext;
    logic signed [`FLU_XLEN:0]     operand_b_ext;
    logic signed [2*`FLU_XLEN+1:0] product;
    flu_pkg::xlen_t                result_d;
    logic                          mult_valid_q;
    flu_pkg::xlen_t                result_q;
    flu_pkg::trans_id_t            trans_id_q;

    // ------------------------------------------------------------
    // Signed product on one extra bit per operand
    // ------------------------------------------------------------
    assign sign_a = fu_data_i.operation inside {flu_pkg::MULH, flu_pkg::MULHSU};
    assign sign_b = (fu_data_i.operation == flu_pkg::MULH);

    assign operand_a_ext = {sign_a & fu_data_i.operand_a[`FLU_XLEN-1], fu_data_i.operand_a};
    assign operand_b_ext = {sign_b & fu_data_i.operand_b[`FLU_XLEN-1], fu_data_i.operand_b};
    assign product       = operand_a_ext * operand_b_ext;

    // Low half for MUL, high half for the rest
    assign result_d = (fu_data_i.operation == flu_pkg::MUL) ? product[`FLU_XLEN-1:0]
                                                            : product[2*`FLU_XLEN-1:`FLU_XLEN];

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mult_valid_q <= 1'b0;
        end else begin
            mult_valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= fu_data_i.trans_id;
    end

    assign result_o        = result_q;
    assign mult_valid_o    = mult_valid_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

//--- hdl/flu_top.sv
// Fixed-latency unit: ALU, branch unit, CSR buffer and multiplier
// Issuer keeps strobes one-hot and avoids the multiply write-back cycle
`timescale 1ns/10ps

module flu_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  flu_pkg::fu_data_t        fu_data_i,
    input  flu_pkg::xlen_t           pc_i,
    input  logic                     is_compressed_instr_i,
    input  flu_pkg::branch_predict_t branch_predict_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  logic                     csr_commit_i,
    output flu_pkg::xlen_t           flu_result_o,
    output flu_pkg::trans_id_t       flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    output flu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                     resolve_branch_o,
    output flu_pkg::csr_addr_t       csr_addr_o
);

    flu_pkg::fu_data_t  alu_data;
    flu_pkg::fu_data_t  mult_data;
    flu_pkg::xlen_t     alu_result;
    flu_pkg::xlen_t     link_result;
    flu_pkg::xlen_t     csr_result;
    flu_pkg::xlen_t     mult_result;
    flu_pkg::trans_id_t mult_trans_id;
    logic               alu_branch_res;
    logic               any_valid;
    logic               csr_ready;
    logic               mult_valid;

    // ------------------------------------------------------------
    // Operand silencing
    // ------------------------------------------------------------
    assign alu_data  = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    // Branch unit watches every issue for a stray taken prediction
    assign any_valid = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    flu_alu u_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    flu_branch_unit u_branch_unit (
        .fu_data_i             (fu_data_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .branch_valid_i        (branch_valid_i),
        .fu_valid_i            (any_valid),
        .branch_comp_res_i     (alu_branch_res),
        .branch_predict_i      (branch_predict_i),
        .link_o                (link_result),
        .resolved_branch_o     (resolved_branch_o),
        .resolve_branch_o      (resolve_branch_o)
    );

    flu_csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    flu_mult u_mult (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (mult_data),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

    // ------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    // Link address unless a higher priority unit writes
    always_comb begin
        flu_result_o   = link_result;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

endmodule

//--- tb/tb_clock_gen.sv
// Clock and active-low reset for the testbench
// Reset is released 1 ns after the last rising edge of the reset window
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned period_ns    = 10,
    parameter int unsigned reset_cycles = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

//--- tb/tb_flu.sv
// Random issue test of the fixed-latency unit against a behavioral model
// Inputs change 1 ns after the rising edge, outputs are sampled 5 ns after it
// Stimulus keeps strobes one-hot and idles while the CSR buffer is full
`timescale 1ns/10ps
`include "flu_consts.svh"

module tb_flu;

    localparam int unsigned num_trans    = 2000;
    localparam int unsigned period_ns    = 10;
    localparam int unsigned reset_cycles = 16;
    localparam int unsigned shamt_bits   = $clog2(`FLU_XLEN);
    localparam int unsigned timeout_ns   = (num_trans * 20 + reset_cycles) * period_ns;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    flu_pkg::fu_data_t        fu_data;
    flu_pkg::xlen_t           pc;
    logic                     is_compressed;
    flu_pkg::branch_predict_t predict;
    logic                     alu_valid;
    logic                     branch_valid;
    logic                     csr_valid;
    logic                     mult_valid;
    logic                     csr_commit;
    flu_pkg::xlen_t           flu_result;
    flu_pkg::trans_id_t       flu_trans_id;
    logic                     flu_valid;
    logic                     flu_ready;
    flu_pkg::bp_resolve_t     resolved_branch;
    logic                     resolve_branch;
    flu_pkg::csr_addr_t       csr_addr;

    // Model state and error counters
    integer             seed;
    int unsigned        xlen_errors;
    int unsigned        id_errors;
    int unsigned        addr_errors;
    int unsigned        resolve_errors;
    int unsigned        bit_errors;
    logic               csr_busy;
    flu_pkg::csr_addr_t csr_held_addr;
    logic               mult_pending;
    flu_pkg::xlen_t     mult_held_result;
    flu_pkg::trans_id_t mult_held_id;

    flu_pkg::fu_op_e alu_ops [10] = '{flu_pkg::ADD, flu_pkg::SUB, flu_pkg::AND, flu_pkg::OR,
                                      flu_pkg::XOR, flu_pkg::SLL, flu_pkg::SRL, flu_pkg::SRA,
                                      flu_pkg::SLT, flu_pkg::SLTU};
    flu_pkg::fu_op_e branch_ops [8] = '{flu_pkg::EQ, flu_pkg::NE, flu_pkg::LTS, flu_pkg::GES,
                                        flu_pkg::LTU, flu_pkg::GEU, flu_pkg::JAL, flu_pkg::JALR};
    flu_pkg::fu_op_e mult_ops [4] = '{flu_pkg::MUL, flu_pkg::MULH, flu_pkg::MULHU,
                                      flu_pkg::MULHSU};

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    flu_top UUT (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .flush_i               (flush),
        .fu_data_i             (fu_data),
        .pc_i                  (pc),
        .is_compressed_instr_i (is_compressed),
        .branch_predict_i      (predict),
        .alu_valid_i           (alu_valid),
        .branch_valid_i        (branch_valid),
        .csr_valid_i           (csr_valid),
        .mult_valid_i          (mult_valid),
        .csr_commit_i          (csr_commit),
        .flu_result_o          (flu_result),
        .flu_trans_id_o        (flu_trans_id),
        .flu_valid_o           (flu_valid),
        .flu_ready_o           (flu_ready),
        .resolved_branch_o     (resolved_branch),
        .resolve_branch_o      (resolve_branch),
        .csr_addr_o            (csr_addr)
    );

    // ------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------
    function automatic flu_pkg::xlen_t rand_word();
        rand_word = flu_pkg::xlen_t'($random(seed));
    endfunction

    function automatic logic rand_bit();
        flu_pkg::xlen_t word;
        word     = rand_word();
        rand_bit = word[0];
    endfunction

    function automatic flu_pkg::xlen_t alu_model(input flu_pkg::fu_op_e op,
                                                 input flu_pkg::xlen_t a, input flu_pkg::xlen_t b);
        case (op)
            flu_pkg::ADD:  return a + b;
            flu_pkg::SUB:  return a - b;
            flu_pkg::AND:  return a & b;
            flu_pkg::OR:   return a | b;
            flu_pkg::XOR:  return a ^ b;
            flu_pkg::SLL:  return a << b[shamt_bits-1:0];
            flu_pkg::SRL:  return a >> b[shamt_bits-1:0];
            flu_pkg::SRA:  return flu_pkg::xlen_t'($signed(a) >>> b[shamt_bits-1:0]);
            flu_pkg::SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            flu_pkg::SLTU: return (a < b) ? 1 : 0;
            default:       return '0;
        endcase
    endfunction

    function automatic logic cond_model(input flu_pkg::fu_op_e op,
                                        input flu_pkg::xlen_t a, input flu_pkg::xlen_t b);
        case (op)
            flu_pkg::EQ:  return a == b;
            flu_pkg::NE:  return a != b;
            flu_pkg::LTS: return $signed(a) < $signed(b);
            flu_pkg::GES: return $signed(a) >= $signed(b);
            flu_pkg::LTU: return a < b;
            flu_pkg::GEU: return a >= b;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic flu_pkg::xlen_t target_model(input flu_pkg::fu_op_e op,
                                                    input flu_pkg::xlen_t pc_val,
                                                    input flu_pkg::xlen_t a,
                                                    input flu_pkg::xlen_t imm);
        if (op == flu_pkg::JALR) begin
            return (a + imm) & ~flu_pkg::xlen_t'(1);
        end
        return pc_val + imm;
    endfunction

    // Product taken modulo 2^(2*XLEN) after extending each operand by its kind
    function automatic flu_pkg::xlen_t mult_model(input flu_pkg::fu_op_e op,
                                                  input flu_pkg::xlen_t a, input flu_pkg::xlen_t b);
        logic [2*`FLU_XLEN-1:0] wide_a;
        logic [2*`FLU_XLEN-1:0] wide_b;
        logic [2*`FLU_XLEN-1:0] product;
        wide_a  = {{`FLU_XLEN{(op == flu_pkg::MULH || op == flu_pkg::MULHSU) && a[`FLU_XLEN-1]}}, a};
        wide_b  = {{`FLU_XLEN{(op == flu_pkg::MULH) && b[`FLU_XLEN-1]}}, b};
        product = wide_a * wide_b;
        return (op == flu_pkg::MUL) ? product[`FLU_XLEN-1:0] : product[2*`FLU_XLEN-1:`FLU_XLEN];
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_xlen(input flu_pkg::xlen_t actual, input flu_pkg::xlen_t expected,
                              input string what);
        if (actual !== expected) begin
            xlen_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_trans_id(input flu_pkg::trans_id_t actual,
                                  input flu_pkg::trans_id_t expected, input string what);
        if (actual !== expected) begin
            id_errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_csr_addr(input flu_pkg::csr_addr_t actual,
                                  input flu_pkg::csr_addr_t expected, input string what);
        if (actual !== expected) begin
            addr_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_resolve(input flu_pkg::bp_resolve_t actual,
                                 input flu_pkg::bp_resolve_t expected, input string what);
        if (actual !== expected) begin
            resolve_errors++;
            $display("CHECK FAILED at %0t: %s is v%b pc %h tgt %h t%b m%b, expected tgt %h t%b m%b",
                     $time, what, actual.valid, actual.pc, actual.target_address,
                     actual.is_taken, actual.is_mispredict, expected.target_address,
                     expected.is_taken, expected.is_mispredict);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            bit_errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus, checking and model update
    // ------------------------------------------------------------
    task automatic drive_issue();
        int unsigned kind;
        kind                    = rand_word() % 8;
        alu_valid               = 1'b0;
        branch_valid            = 1'b0;
        csr_valid               = 1'b0;
        mult_valid              = 1'b0;
        csr_commit              = 1'b0;
        flush                   = (rand_word() % 16) == 0;
        fu_data.operation       = flu_pkg::ADD;
        fu_data.operand_a       = rand_word();
        fu_data.operand_b       = rand_bit() ? rand_word() : fu_data.operand_a;
        fu_data.imm             = rand_word();
        fu_data.trans_id        = flu_pkg::trans_id_t'(rand_word());
        pc                      = rand_word();
        is_compressed           = rand_bit();
        predict.predict_taken   = rand_bit();
        predict.predict_address = rand_word();
        if (csr_busy) begin
            csr_commit = (rand_word() % 4) == 0;
        end else if (kind >= 6) begin
            // Back-to-back multiplies are legal while a result emerges
            fu_data.operation = mult_ops[rand_word() % 4];
            mult_valid        = 1'b1;
        end else if (!mult_pending && kind != 0) begin
            if (kind <= 2) begin
                fu_data.operation = alu_ops[rand_word() % 10];
                alu_valid         = 1'b1;
            end else if (kind <= 4) begin
                fu_data.operation = branch_ops[rand_word() % 8];
                if (rand_bit()) begin
                    predict.predict_address = target_model(fu_data.operation, pc,
                                                           fu_data.operand_a, fu_data.imm);
                end
                branch_valid = 1'b1;
            end else begin
                fu_data.operation = flu_pkg::CSR_RW;
                csr_valid         = 1'b1;
            end
        end
    endtask

    task automatic check_outputs();
        logic                 exp_valid;
        logic                 taken;
        flu_pkg::xlen_t       link;
        flu_pkg::xlen_t       target;
        flu_pkg::xlen_t       exp_result;
        flu_pkg::trans_id_t   exp_id;
        flu_pkg::bp_resolve_t exp_res;
        link   = (is_compressed && (`FLU_RVC != 0)) ? pc + 2 : pc + 4;
        target = target_model(fu_data.operation, pc, fu_data.operand_a, fu_data.imm);
        taken  = (fu_data.operation inside {flu_pkg::JAL, flu_pkg::JALR}) ||
                 cond_model(fu_data.operation, fu_data.operand_a, fu_data.operand_b);
        exp_valid  = alu_valid | branch_valid | csr_valid | mult_pending;
        exp_result = link;
        exp_id     = fu_data.trans_id;
        if (alu_valid) begin
            exp_result = alu_model(fu_data.operation, fu_data.operand_a, fu_data.operand_b);
        end else if (csr_valid) begin
            exp_result = fu_data.operand_a;
        end else if (mult_pending) begin
            exp_result = mult_held_result;
            exp_id     = mult_held_id;
        end
        check_bit(flu_valid, exp_valid, "flu_valid_o");
        check_bit(flu_ready, !csr_busy, "flu_ready_o");
        if (exp_valid) begin
            check_xlen(flu_result, exp_result, "flu_result_o");
            check_trans_id(flu_trans_id, exp_id, "flu_trans_id_o");
        end
        if (csr_busy) begin
            check_csr_addr(csr_addr, csr_held_addr, "csr_addr_o");
        end
        exp_res    = '0;
        exp_res.pc = pc;
        if (branch_valid) begin
            exp_res.valid          = 1'b1;
            exp_res.is_taken       = taken;
            exp_res.target_address = taken ? target : link;
            exp_res.is_mispredict  = (taken != predict.predict_taken) ||
                                     (taken && (target != predict.predict_address));
        end else if ((alu_valid | csr_valid | mult_valid) && predict.predict_taken) begin
            exp_res.valid          = 1'b1;
            exp_res.target_address = link;
            exp_res.is_mispredict  = 1'b1;
        end
        check_bit(resolve_branch, exp_res.valid, "resolve_branch_o");
        if (exp_res.valid) begin
            check_resolve(resolved_branch, exp_res, "resolved_branch_o");
        end
    endtask

    // State after the coming rising edge
    task automatic advance_model();
        if (csr_valid) begin
            csr_held_addr = fu_data.operand_b[`FLU_CSR_ADDR_BITS-1:0];
        end
        if (flush) begin
            csr_busy = 1'b0;
        end else if (csr_valid) begin
            csr_busy = 1'b1;
        end else if (csr_commit) begin
            csr_busy = 1'b0;
        end
        mult_pending = mult_valid && !flush;
        if (mult_valid) begin
            mult_held_result = mult_model(fu_data.operation, fu_data.operand_a, fu_data.operand_b);
            mult_held_id     = fu_data.trans_id;
        end
    endtask

    initial begin : stimulus
        int unsigned total;
        seed             = 32'h78f64c36;
        xlen_errors      = 0;
        id_errors        = 0;
        addr_errors      = 0;
        resolve_errors   = 0;
        bit_errors       = 0;
        csr_busy         = 1'b0;
        csr_held_addr    = '0;
        mult_pending     = 1'b0;
        mult_held_result = '0;
        mult_held_id     = '0;
        flush            = 1'b0;
        fu_data          = '0;
        pc               = '0;
        is_compressed    = 1'b0;
        predict          = '0;
        alu_valid        = 1'b0;
        branch_valid     = 1'b0;
        csr_valid        = 1'b0;
        mult_valid       = 1'b0;
        csr_commit       = 1'b0;

        // Idle state right after reset
        wait (rst_n === 1'b1);
        #4;
        check_bit(flu_valid, 1'b0, "flu_valid_o after reset");
        check_bit(resolve_branch, 1'b0, "resolve_branch_o after reset");
        check_bit(flu_ready, 1'b1, "flu_ready_o after reset");

        repeat (num_trans) begin
            @(posedge clk);
            #1;
            drive_issue();
            #4;
            check_outputs();
            advance_model();
        end

        total = xlen_errors + id_errors + addr_errors + resolve_errors + bit_errors;
        $display("Errors: result %0d, tag %0d, address %0d, resolve %0d, flag %0d, total %0d",
                 xlen_errors, id_errors, addr_errors, resolve_errors, bit_errors, total);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, the test did not reach its end", timeout_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- flu.f
+incdir+hdl
hdl/flu_pkg.sv
hdl/flu_alu.sv
hdl/flu_branch_unit.sv
hdl/flu_csr_buffer.sv
hdl/flu_mult.sv
hdl/flu_top.sv
tb/tb_clock_gen.sv
tb/tb_flu.sv

//--- Bender.yml
package:
  name: flu

export_include_dirs:
  - hdl

sources:
  - hdl/flu_pkg.sv
  - hdl/flu_alu.sv
  - hdl/flu_branch_unit.sv
  - hdl/flu_csr_buffer.sv
  - hdl/flu_mult.sv
  - hdl/flu_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_flu.sv
